// File: pol_top.f
+incdir+verif
src/pol_cfg_pkg.sv
src/pol_mem_pkg.sv
src/pol_ctrl.sv
src/map_unpacker.sv
src/neighbor_gather.sv
src/max_pool_unit.sv
src/pol_top.sv
verif/pol_tb.sv

// File: src/map_unpacker.sv
// ==============================
// Map word collector
// Gathers the map words of one point into the
// neighbor index array used by the gather stage
// ==============================

module map_unpacker #(
    parameter int MAP_SLOTS = 8
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              busy,
    input  logic                                              map_dat_vld,
    input  logic [pol_cfg_pkg::SRAM_WIDTH-1:0]                map_dat,
    output logic                                              map_dat_rdy,
    input  logic                                              slot_rdy,
    output logic                                              slot_vld,
    output logic [MAP_SLOTS-1:0][pol_cfg_pkg::IDX_WIDTH-1:0]  slots
);
    import pol_cfg_pkg::*;

    localparam int WORDS  = MAP_SLOTS * IDX_WIDTH / SRAM_WIDTH;
    localparam int WORD_W = (WORDS > 1) ? $clog2(WORDS) : 1;

    logic [WORDS-1:0][SRAM_WIDTH-1:0] words_q;
    logic [WORD_W-1:0]                wd_q;
    logic                             dat_hs;
    logic                             last_word;

    // Stalls while a full array waits for the gather stage
    assign map_dat_rdy = !slot_vld;
    assign dat_hs      = map_dat_vld & map_dat_rdy;
    assign last_word   = (wd_q == WORD_W'(WORDS - 1));

    // First word holds the lowest slots
    assign slots = words_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wd_q     <= '0;
            slot_vld <= 1'b0;
        end else if (!busy) begin
            wd_q     <= '0;
            slot_vld <= 1'b0;
        end else begin
            if (dat_hs) begin
                wd_q <= last_word ? '0 : wd_q + 1'b1;
            end
            if (dat_hs && last_word) begin
                slot_vld <= 1'b1;
            end else if (slot_rdy) begin
                slot_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dat_hs) begin
            words_q[wd_q] <= map_dat;
        end
    end

endmodule

// File: src/max_pool_unit.sv
// ==============================
// Lane-wise max pooling and feature write
// Folds k neighbor vectors into one pooled vector
// per point and group and writes it back
// ==============================

module max_pool_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pol_cfg_pkg::pol_cfg_t job_cfg,
    input  logic                  ofm_rd_dat_vld,
    input  pol_mem_pkg::act_vec_t ofm_rd_dat,
    output logic                  ofm_rd_dat_rdy,
    output logic                  ofm_wr_vld,
    output pol_mem_pkg::ofm_wr_t  ofm_wr,
    input  logic                  ofm_wr_rdy,
    output logic                  job_done
);
    import pol_cfg_pkg::*;
    import pol_mem_pkg::*;

    localparam int LANE_SH = $clog2(LANES);

    logic [K_WIDTH-1:0]   n_q;
    logic [K_WIDTH-1:0]   k_last;
    logic [CHN_WIDTH-1:0] g_q;
    logic [CHN_WIDTH-1:0] grp_num;
    logic [CHN_WIDTH-1:0] g_last;
    logic [IDX_WIDTH-1:0] p_q;
    logic                 rd_hs;
    logic                 wr_hs;
    logic                 last_n;
    logic                 last_g;
    logic                 last_p;
    logic                 wr_last_q;
    act_vec_t             max_q;
    act_vec_t             max_nxt;

    assign grp_num = job_cfg.chn >> LANE_SH;
    assign k_last  = job_cfg.k - 1'b1;
    assign g_last  = grp_num - 1'b1;
    assign last_n  = (n_q == k_last);
    assign last_g  = (g_q == g_last);
    assign last_p  = (p_q == job_cfg.nip - 1'b1);

    // A stalled write blocks further responses
    assign ofm_rd_dat_rdy = !ofm_wr_vld | ofm_wr_rdy;
    assign rd_hs          = ofm_rd_dat_vld & ofm_rd_dat_rdy;
    assign wr_hs          = ofm_wr_vld & ofm_wr_rdy;
    assign job_done       = wr_hs & wr_last_q;

    // First neighbor loads, later ones keep the larger value
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            if (n_q == '0 || ofm_rd_dat[i] > max_q[i]) begin
                max_nxt[i] = ofm_rd_dat[i];
            end else begin
                max_nxt[i] = max_q[i];
            end
        end
    end

    // ==============================
    // Response counters
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            n_q <= '0;
            g_q <= '0;
            p_q <= '0;
        end else if (rd_hs) begin
            n_q <= last_n ? '0 : n_q + 1'b1;
            if (last_n) begin
                g_q <= last_g ? '0 : g_q + 1'b1;
                if (last_g) begin
                    p_q <= last_p ? '0 : p_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_wr_vld <= 1'b0;
            wr_last_q  <= 1'b0;
        end else if (rd_hs && last_n) begin
            ofm_wr_vld <= 1'b1;
            wr_last_q  <= last_g & last_p;
        end else if (wr_hs) begin
            ofm_wr_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            max_q <= max_nxt;
        end
        if (rd_hs && last_n) begin
            ofm_wr.dat  <= max_nxt;
            ofm_wr.addr <= job_cfg.ofm_wr_base + p_q * grp_num + IDX_WIDTH'(g_q);
        end
    end

endmodule

// File: src/neighbor_gather.sv
// ==============================
// Neighbor feature read issue
// For each channel group walks the k neighbors of
// the current point and requests their features
// ==============================

module neighbor_gather #(
    parameter int MAP_SLOTS = 8
) (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  pol_cfg_pkg::pol_cfg_t                             job_cfg,
    input  logic                                              slot_vld,
    input  logic [MAP_SLOTS-1:0][pol_cfg_pkg::IDX_WIDTH-1:0]  slots,
    output logic                                              slot_rdy,
    output logic                                              ofm_rd_addr_vld,
    output logic [pol_cfg_pkg::IDX_WIDTH-1:0]                 ofm_rd_addr,
    input  logic                                              ofm_rd_addr_rdy
);
    import pol_cfg_pkg::*;

    localparam int LANE_SH = $clog2(LANES);

    logic [K_WIDTH-1:0]   n_q;
    logic [K_WIDTH-1:0]   k_last;
    logic [CHN_WIDTH-1:0] g_q;
    logic [CHN_WIDTH-1:0] grp_num;
    logic [CHN_WIDTH-1:0] g_last;
    logic                 addr_hs;
    logic                 last_n;
    logic                 last_g;

    // ==============================
    // Loop bounds
    // ==============================
    assign grp_num = job_cfg.chn >> LANE_SH;
    assign k_last  = job_cfg.k - 1'b1;
    assign g_last  = grp_num - 1'b1;
    assign last_n  = (n_q == k_last);
    assign last_g  = (g_q == g_last);

    // ==============================
    // Address issue
    // ==============================

    // One request per cycle while the index array is held
    assign ofm_rd_addr_vld = slot_vld;
    assign addr_hs         = ofm_rd_addr_vld & ofm_rd_addr_rdy;

    // Feature memory is laid out point-major, group-minor
    assign ofm_rd_addr = job_cfg.ofm_rd_base + grp_num * slots[n_q] + IDX_WIDTH'(g_q);

    // Array is free once the last group has been requested
    assign slot_rdy = addr_hs & last_n & last_g;

    // Neighbor is the inner loop, group the outer one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            n_q <= '0;
            g_q <= '0;
        end else if (addr_hs) begin
            if (last_n) begin
                n_q <= '0;
                g_q <= last_g ? '0 : g_q + 1'b1;
            end else begin
                n_q <= n_q + 1'b1;
            end
        end
    end

endmodule

// File: src/pol_cfg_pkg.sv
// ==============================
// Job configuration for the pooling core
// Fixed data widths and the configuration word
// Modules import this inside their body
// ==============================

package pol_cfg_pkg;

    // ==============================
    // Data widths
    // ==============================

    // Addresses and neighbor indices share one width
    localparam int IDX_WIDTH  = 16;
    localparam int ACT_WIDTH  = 8;

    // Channels compared per cycle form one channel group
    localparam int LANES      = 8;
    localparam int CHN_WIDTH  = 8;

    // One map word as delivered by the global buffer
    localparam int SRAM_WIDTH = 64;
    localparam int K_WIDTH    = 4;

    // ==============================
    // Configuration word
    // ==============================

    // Point count sits in the low bits
    // chn must be a multiple of LANES
    typedef struct packed {
        logic [IDX_WIDTH-1:0] ofm_wr_base;
        logic [IDX_WIDTH-1:0] ofm_rd_base;
        logic [IDX_WIDTH-1:0] map_base;
        logic [CHN_WIDTH-1:0] chn;
        logic [K_WIDTH-1:0]   k;
        logic [IDX_WIDTH-1:0] nip;
    } pol_cfg_t;

endpackage

// File: src/pol_ctrl.sv
// ==============================
// Job controller of the pooling core
// Latches the configuration, walks all points
// and issues one map read at a time
// ==============================

module pol_ctrl #(
    parameter int MAP_SLOTS = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cfg_vld,
    input  pol_cfg_pkg::pol_cfg_t             cfg,
    output logic                              cfg_rdy,
    output logic                              busy,
    output pol_cfg_pkg::pol_cfg_t             job_cfg,
    output logic                              map_addr_vld,
    output logic [pol_cfg_pkg::IDX_WIDTH-1:0] map_addr,
    input  logic                              map_addr_rdy,
    input  logic                              map_dat_vld,
    input  logic                              map_dat_rdy,
    input  logic                              job_done
);
    import pol_cfg_pkg::*;

    localparam int WORDS  = MAP_SLOTS * IDX_WIDTH / SRAM_WIDTH;
    localparam int WORD_W = (WORDS > 1) ? $clog2(WORDS) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MAP,
        ST_WAIT
    } state_t;

    state_t               state_q;
    logic [IDX_WIDTH-1:0] pt_q;
    logic [WORD_W-1:0]    wd_q;
    logic                 cfg_hs;
    logic                 addr_hs;
    logic                 dat_hs;
    logic                 last_word;
    logic                 last_pt;

    assign cfg_rdy   = (state_q == ST_IDLE);
    assign busy      = !cfg_rdy;
    assign cfg_hs    = cfg_vld & cfg_rdy;
    assign addr_hs   = map_addr_vld & map_addr_rdy;
    assign dat_hs    = map_dat_vld & map_dat_rdy;
    assign last_word = (wd_q == WORD_W'(WORDS - 1));
    assign last_pt   = (pt_q == job_cfg.nip - 1'b1);

    // Map words of one point are contiguous
    assign map_addr = job_cfg.map_base + IDX_WIDTH'(pt_q * WORDS) + IDX_WIDTH'(wd_q);

    // ==============================
    // Job FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            job_cfg <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (cfg_hs) begin
                        state_q <= ST_MAP;
                        job_cfg <= cfg;
                    end
                end
                ST_MAP: begin
                    if (addr_hs && last_word && last_pt) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (job_done) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Next request only after the previous word has landed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            map_addr_vld <= 1'b0;
            pt_q         <= '0;
            wd_q         <= '0;
        end else if (cfg_hs) begin
            map_addr_vld <= 1'b1;
            pt_q         <= '0;
            wd_q         <= '0;
        end else if (addr_hs) begin
            map_addr_vld <= 1'b0;
            wd_q         <= last_word ? '0 : wd_q + 1'b1;
            if (last_word) begin
                pt_q <= pt_q + 1'b1;
            end
        end else if (dat_hs && state_q == ST_MAP) begin
            map_addr_vld <= 1'b1;
        end
    end

endmodule

// File: src/pol_mem_pkg.sv
// ==============================
// Global buffer data types
// Feature vectors read by the core and the
// write beat it sends back to the buffer
// ==============================

package pol_mem_pkg;

    // ==============================
    // Feature data
    // ==============================

    // One channel group of activations
    // Lane 0 sits in the low bits
    typedef logic [pol_cfg_pkg::LANES-1:0][pol_cfg_pkg::ACT_WIDTH-1:0] act_vec_t;

    // ==============================
    // Feature write beat
    // ==============================

    // Address of the pooled group and its data
    // Word granular address with one group per word
    typedef struct packed {
        logic [pol_cfg_pkg::IDX_WIDTH-1:0] addr;
        act_vec_t                          dat;
    } ofm_wr_t;

    // Total width is IDX_WIDTH + LANES * ACT_WIDTH
    // 80 bits with the default widths

endpackage

// File: src/pol_top.sv
// ==============================
// Point-cloud max pooling core
// Map fetch, neighbor gather and pooling behind
// valid/ready ports to the global buffer
// ==============================

module pol_top #(
    parameter int MAP_SLOTS = 8
) (
    input  logic                               clk,
    input  logic                               rst_n,
    // Configuration
    input  logic                               cfg_vld,
    output logic                               cfg_rdy,
    input  pol_cfg_pkg::pol_cfg_t              cfg,
    // Map read
    output logic                               map_addr_vld,
    output logic [pol_cfg_pkg::IDX_WIDTH-1:0]  map_addr,
    input  logic                               map_addr_rdy,
    input  logic                               map_dat_vld,
    input  logic [pol_cfg_pkg::SRAM_WIDTH-1:0] map_dat,
    output logic                               map_dat_rdy,
    // Feature read
    output logic                               ofm_rd_addr_vld,
    output logic [pol_cfg_pkg::IDX_WIDTH-1:0]  ofm_rd_addr,
    input  logic                               ofm_rd_addr_rdy,
    input  logic                               ofm_rd_dat_vld,
    input  pol_mem_pkg::act_vec_t              ofm_rd_dat,
    output logic                               ofm_rd_dat_rdy,
    // Feature write
    output logic                               ofm_wr_vld,
    output pol_mem_pkg::ofm_wr_t               ofm_wr,
    input  logic                               ofm_wr_rdy
);
    import pol_cfg_pkg::*;

    logic                                busy;
    pol_cfg_t                            job_cfg;
    logic                                slot_vld;
    logic                                slot_rdy;
    logic [MAP_SLOTS-1:0][IDX_WIDTH-1:0] slots;
    logic                                job_done;

    pol_ctrl #(.MAP_SLOTS(MAP_SLOTS)) i_ctrl (
        .clk, .rst_n, .cfg_vld, .cfg, .cfg_rdy, .busy, .job_cfg,
        .map_addr_vld, .map_addr, .map_addr_rdy,
        .map_dat_vld, .map_dat_rdy, .job_done
    );

    map_unpacker #(.MAP_SLOTS(MAP_SLOTS)) i_unpacker (
        .clk, .rst_n, .busy, .map_dat_vld, .map_dat, .map_dat_rdy,
        .slot_rdy, .slot_vld, .slots
    );

    neighbor_gather #(.MAP_SLOTS(MAP_SLOTS)) i_gather (
        .clk, .rst_n, .job_cfg, .slot_vld, .slots, .slot_rdy,
        .ofm_rd_addr_vld, .ofm_rd_addr, .ofm_rd_addr_rdy
    );

    max_pool_unit i_pool (
        .clk, .rst_n, .job_cfg, .ofm_rd_dat_vld, .ofm_rd_dat, .ofm_rd_dat_rdy,
        .ofm_wr_vld, .ofm_wr, .ofm_wr_rdy, .job_done
    );

endmodule

// File: verif/pol_ref.svh
// ==============================
// Global buffer model and reference pooling
// Included in the testbench module body after
// the DUT signals are declared
// ==============================

`ifndef POL_REF_SVH
`define POL_REF_SVH

localparam int MEM_DEPTH = 4096;
localparam int WORDS     = MAP_SLOTS * IDX_WIDTH / SRAM_WIDTH;

logic [SRAM_WIDTH-1:0] map_mem [MEM_DEPTH];
act_vec_t              feat_mem [MEM_DEPTH];
ofm_wr_t               exp_q [$];
logic [IDX_WIDTH-1:0]  rd_addr_q [$];
int                    rd_due_q [$];
logic [IDX_WIDTH-1:0]  map_pend_addr;
bit                    map_pend;
int                    map_due;
int                    cyc;
int                    stall_left;

// Ready percentages, stall length and latency in cycles
int                    map_pct;
int                    rd_pct;
int                    wr_pct;
int                    stall_max;
int                    max_lat;

// Pooled vectors in write order by point and then group
function automatic void build_expected(pol_cfg_t c);
    int                    grp;
    logic [SRAM_WIDTH-1:0] word;
    logic [IDX_WIDTH-1:0]  idx;
    act_vec_t              v;
    ofm_wr_t               w;
    grp = c.chn / LANES;
    for (int p = 0; p < c.nip; p++) begin
        for (int g = 0; g < grp; g++) begin
            w.dat = '0;
            for (int n = 0; n < c.k; n++) begin
                word = map_mem[(c.map_base + p * WORDS + n * IDX_WIDTH / SRAM_WIDTH) % MEM_DEPTH];
                idx  = word[(n * IDX_WIDTH) % SRAM_WIDTH +: IDX_WIDTH];
                v    = feat_mem[(c.ofm_rd_base + grp * idx + g) % MEM_DEPTH];
                for (int l = 0; l < LANES; l++) begin
                    if (v[l] > w.dat[l]) begin
                        w.dat[l] = v[l];
                    end
                end
            end
            w.addr = IDX_WIDTH'(c.ofm_wr_base + p * grp + g);
            exp_q.push_back(w);
        end
    end
endfunction

// Buffer outputs for the coming cycle are set on the falling edge
task automatic drive_buffer();
    map_addr_rdy    = ($urandom % 100) < map_pct;
    ofm_rd_addr_rdy = ($urandom % 100) < rd_pct;
    map_dat_vld     = map_pend && (cyc >= map_due);
    map_dat         = map_mem[map_pend_addr % MEM_DEPTH];
    ofm_rd_dat_vld  = (rd_addr_q.size() > 0) && (rd_due_q[0] <= cyc);
    ofm_rd_dat      = ofm_rd_dat_vld ? feat_mem[rd_addr_q[0] % MEM_DEPTH] : '0;
    // Write stalls come in bursts
    if (stall_left > 0) begin
        ofm_wr_rdy = 1'b0;
        stall_left--;
    end else if (($urandom % 100) < wr_pct) begin
        ofm_wr_rdy = 1'b1;
    end else begin
        ofm_wr_rdy = 1'b0;
        stall_left = $urandom % (stall_max + 1);
    end
endtask

// Bookkeeping for the handshakes of the next rising edge
task automatic note_handshakes();
    if (map_dat_vld && map_dat_rdy) begin
        map_pend = 1'b0;
    end
    if (map_addr_vld && map_addr_rdy) begin
        map_pend      = 1'b1;
        map_pend_addr = map_addr;
        map_due       = cyc + 1 + $urandom % (max_lat + 1);
    end
    if (ofm_rd_dat_vld && ofm_rd_dat_rdy) begin
        void'(rd_addr_q.pop_front());
        void'(rd_due_q.pop_front());
    end
    // Queue front gates the responses, so order is kept
    if (ofm_rd_addr_vld && ofm_rd_addr_rdy) begin
        rd_addr_q.push_back(ofm_rd_addr);
        rd_due_q.push_back(cyc + 1 + $urandom % (max_lat + 1));
    end
endtask

`endif

// File: verif/pol_tb.sv
// ==============================
// Testbench for the max pooling core
// Random latency buffer model, reference
// pooling and a write compare process
// ==============================

module pol_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import pol_cfg_pkg::*;
    import pol_mem_pkg::*;

    localparam int MAP_SLOTS = 8;
    localparam int TIMEOUT   = 20000;

    logic                  clk;
    logic                  rst_n;
    logic                  cfg_vld;
    logic                  cfg_rdy;
    pol_cfg_t              cfg;
    logic                  map_addr_vld;
    logic [IDX_WIDTH-1:0]  map_addr;
    logic                  map_addr_rdy;
    logic                  map_dat_vld;
    logic [SRAM_WIDTH-1:0] map_dat;
    logic                  map_dat_rdy;
    logic                  ofm_rd_addr_vld;
    logic [IDX_WIDTH-1:0]  ofm_rd_addr;
    logic                  ofm_rd_addr_rdy;
    logic                  ofm_rd_dat_vld;
    act_vec_t              ofm_rd_dat;
    logic                  ofm_rd_dat_rdy;
    logic                  ofm_wr_vld;
    ofm_wr_t               ofm_wr;
    logic                  ofm_wr_rdy;

    string                 test_name;
    int                    data_errs;
    int                    proto_errs;
    int                    timeouts;
    int                    wr_count;
    bit                    aborted;
    bit                    held_vld;
    ofm_wr_t               held_wr;

    `include "pol_ref.svh"

    pol_top #(.MAP_SLOTS(MAP_SLOTS)) i_pol_top (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Buffer model runs on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            cyc++;
            drive_buffer();
            #1;
            note_handshakes();
        end
    end

    // ==============================
    // Write compare
    // ==============================
    always @(negedge clk) begin
        #1;
        if (rst_n) begin
            if (held_vld) begin
                assert (ofm_wr_vld && ofm_wr == held_wr) else begin
                    $display("** Error [%s] stalled write: expected %h, actual %h (valid %b)",
                             test_name, held_wr, ofm_wr, ofm_wr_vld);
                    data_errs++;
                end
            end
            if (ofm_wr_vld && !ofm_wr_rdy) begin
                assert (!ofm_rd_dat_rdy) else begin
                    $display("[%s] feature responses still accepted while a write is stalled",
                             test_name);
                    proto_errs++;
                end
            end
            if (ofm_wr_vld && ofm_wr_rdy) begin
                check_write();
            end
            held_vld = ofm_wr_vld && !ofm_wr_rdy;
            held_wr  = ofm_wr;
        end
    end

    task automatic check_write();
        ofm_wr_t exp;
        wr_count++;
        assert (exp_q.size() > 0) else begin
            $display("[%s] write to %h accepted with no write left to expect",
                     test_name, ofm_wr.addr);
            proto_errs++;
        end
        if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            assert (ofm_wr.addr == exp.addr) else begin
                $display("** Error [%s] write address: expected %h, actual %h",
                         test_name, exp.addr, ofm_wr.addr);
                data_errs++;
            end
            assert (ofm_wr.dat == exp.dat) else begin
                $display("** Error [%s] write data at %h: expected %h, actual %h",
                         test_name, exp.addr, exp.dat, ofm_wr.dat);
                data_errs++;
            end
        end
    endtask

    function automatic pol_cfg_t make_cfg(int nip, int k, int chn, int mb, int rb, int wb);
        pol_cfg_t c;
        c.nip         = IDX_WIDTH'(nip);
        c.k           = K_WIDTH'(k);
        c.chn         = CHN_WIDTH'(chn);
        c.map_base    = IDX_WIDTH'(mb);
        c.ofm_rd_base = IDX_WIDTH'(rb);
        c.ofm_wr_base = IDX_WIDTH'(wb);
        return c;
    endfunction

    task automatic set_traffic(int m, int r, int w, int s, int l);
        map_pct   = m;
        rd_pct    = r;
        wr_pct    = w;
        stall_max = s;
        max_lat   = l;
    endtask

    task automatic fill_features(logic [7:0] mask);
        for (int a = 0; a < MEM_DEPTH; a++) begin
            for (int l = 0; l < LANES; l++) begin
                feat_mem[a][l] = ACT_WIDTH'($urandom) & mask;
            end
        end
    endtask

    // All-zero, all-255, equal lanes or random vectors picked by address
    task automatic fill_edge_features();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            case ((a ^ (a >> 2) ^ (a >> 7)) % 4)
                0: feat_mem[a] = '0;
                1: feat_mem[a] = '1;
                2: feat_mem[a] = {LANES{a[7:0] ^ a[11:4]}};
                default: begin
                    for (int l = 0; l < LANES; l++) begin
                        feat_mem[a][l] = ACT_WIDTH'($urandom);
                    end
                end
            endcase
        end
    endtask

    // Slots from k up get the index unused when it is not negative
    task automatic fill_map(pol_cfg_t c, int range, int unused);
        logic [MAP_SLOTS-1:0][IDX_WIDTH-1:0] s;
        for (int p = 0; p < c.nip; p++) begin
            for (int i = 0; i < MAP_SLOTS; i++) begin
                if (unused < 0 || i < c.k) begin
                    s[i] = IDX_WIDTH'($urandom % range);
                end else begin
                    s[i] = IDX_WIDTH'(unused);
                end
            end
            for (int w = 0; w < WORDS; w++) begin
                map_mem[c.map_base + p * WORDS + w] = s[w * (SRAM_WIDTH / IDX_WIDTH) +:
                                                        SRAM_WIDTH / IDX_WIDTH];
            end
        end
    endtask

    task automatic report_timeout(string what);
        $display("[%s] timed out waiting for %s", test_name, what);
        timeouts++;
        aborted = 1'b1;
    endtask

    // Applies the configuration on a falling edge once idle
    task automatic start_job(pol_cfg_t c);
        int n;
        if (aborted) return;
        n = 0;
        while (!cfg_rdy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!cfg_rdy) begin
            report_timeout("the core to become idle");
            return;
        end
        build_expected(c);
        wr_count = 0;
        cfg      = c;
        cfg_vld  = 1'b1;
        @(negedge clk);
        cfg_vld  = 1'b0;
        assert (!cfg_rdy) else begin
            $display("[%s] cfg_rdy still high after a configuration handshake", test_name);
            proto_errs++;
        end
    endtask

    task automatic finish_job(pol_cfg_t c);
        int n;
        if (aborted) return;
        n = 0;
        while (!cfg_rdy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!cfg_rdy) begin
            report_timeout("the job to finish");
            return;
        end
        assert (wr_count == c.nip * (c.chn / LANES)) else begin
            $display("** Error [%s] write count: expected %0d, actual %0d",
                     test_name, c.nip * (c.chn / LANES), wr_count);
            data_errs++;
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        pol_cfg_t c1;
        pol_cfg_t c2;
        void'($urandom(32'h95e1a14f));
        rst_n           = 1'b0;
        cfg_vld         = 1'b0;
        cfg             = '0;
        map_addr_rdy    = 1'b0;
        map_dat_vld     = 1'b0;
        map_dat         = '0;
        ofm_rd_addr_rdy = 1'b0;
        ofm_rd_dat_vld  = 1'b0;
        ofm_rd_dat      = '0;
        ofm_wr_rdy      = 1'b0;
        map_pend        = 1'b0;
        map_pend_addr   = '0;
        set_traffic(0, 0, 0, 0, 0);
        repeat (3) @(negedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        test_name = "reset_state";
        assert (cfg_rdy && !map_addr_vld && !ofm_rd_addr_vld && !ofm_wr_vld) else begin
            $display("[%s] handshake outputs not idle after reset", test_name);
            proto_errs++;
        end

        test_name = "full_map";
        set_traffic(80, 80, 90, 2, 3);
        fill_features(8'hff);
        c1 = make_cfg(6, 8, 8, 'h10, 'h100, 'h800);
        fill_map(c1, 256, -1);
        start_job(c1);
        finish_job(c1);

        // Unused slots point at all-255 vectors
        test_name = "partial_neighbors";
        fill_features(8'h7f);
        c1 = make_cfg(5, 3, 32, 'h40, 'h200, 'h900);
        for (int g = 0; g < 4; g++) begin
            feat_mem['h200 + 4 * 100 + g] = '1;
        end
        fill_map(c1, 64, 100);
        start_job(c1);
        finish_job(c1);

        test_name = "back_pressure";
        set_traffic(50, 40, 40, 30, 6);
        fill_features(8'hff);
        c1 = make_cfg(8, 5, 16, 'h60, 'h300, 'ha00);
        fill_map(c1, 200, -1);
        start_job(c1);
        finish_job(c1);

        test_name = "edge_back_to_back";
        set_traffic(70, 70, 60, 8, 2);
        fill_edge_features();
        c1 = make_cfg(4, 8, 16, 'h80, 'h400, 'hb00);
        c2 = make_cfg(3, 1, 24, 'ha0, 'h500, 'hc00);
        fill_map(c1, 256, -1);
        fill_map(c2, 256, -1);
        start_job(c1);
        finish_job(c1);
        start_job(c2);
        finish_job(c2);

        $display("Summary: %0d data errors, %0d protocol errors, %0d timeouts",
                 data_errs, proto_errs, timeouts);
        if (data_errs + proto_errs + timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
